/* include/icache_cfg.svh */
/*
 * instruction cache configuration
 * widths and geometry of the two-way fetch cache
 */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte address and instruction width
`define ICACHE_ADDR_W       32
`define ICACHE_INST_W       32

// one line holds two instructions, same width as the AXI data bus
`define ICACHE_LINE_W       64

// 256 sets of 8-byte lines
`define ICACHE_SET_BITS     8
`define ICACHE_OFFSET_BITS  3
`define ICACHE_TAG_W        (`ICACHE_ADDR_W - `ICACHE_SET_BITS - `ICACHE_OFFSET_BITS)

// for reference only, the RTL is built for exactly two ways
`define ICACHE_WAYS         2

`endif

/* hw/icache_pkg.sv */
/*
 * instruction cache types
 * PC split, fetch request/response, AXI4-Lite read channels, FSM states
 */
`default_nettype none
`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_SET_BITS-1:0] set_index_t;

    typedef struct packed {
        tag_t                          tag;
        set_index_t                    index;
        logic                          word_sel;
        logic [`ICACHE_OFFSET_BITS-2:0] byte_off;
    } fetch_addr_t;

    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_ADDR_W-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_INST_W-1:0] inst;
        logic                      error;
    } fetch_resp_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic                      arvalid;
        logic [`ICACHE_ADDR_W-1:0] araddr;
        logic [2:0]                arprot;
    } axi_ar_t;

    typedef struct packed {
        logic                      rvalid;
        logic [`ICACHE_LINE_W-1:0] rdata;
        axi_resp_e                 rresp;
    } axi_r_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ADDR,
        DATA,
        RESP
    } refill_state_e;

endpackage

`default_nettype wire

/* hw/icache_tag_store.sv */
/*
 * icache tag store
 * tags and valid bits for both ways, hit compare and
 * victim selection with one replacement bit per set
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module icache_tag_store import icache_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire fetch_addr_t lookup_addr,
    input  wire logic        fill,
    input  wire fetch_addr_t fill_addr,
    output logic             hit,
    output logic             hit_way,
    output logic             fill_way
);

    localparam int NUM_SETS = 1 << `ICACHE_SET_BITS;

    tag_t                     tag_mem [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0]      victim;
    logic [1:0]               way_hit;
    set_index_t               lk_idx;
    set_index_t               fl_idx;

    assign lk_idx = lookup_addr.index;
    assign fl_idx = fill_addr.index;

    // ==============================
    // lookup
    // ==============================
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][lk_idx] && (tag_mem[w][lk_idx] == lookup_addr.tag);
        end
    end

    // a tag lives in at most one way of a set
    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // invalid way first, way 0 before way 1
    always_comb begin
        if (!valid[0][fl_idx]) begin
            fill_way = 1'b0;
        end else if (!valid[1][fl_idx]) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim[fl_idx];
        end
    end

    // ==============================
    // fill
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            valid  <= '0;
            victim <= '0;
        end else if (fill) begin
            valid[fill_way][fl_idx] <= 1'b1;
            // next victim is the way we did not just fill
            victim[fl_idx]          <= ~fill_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_way][fl_idx] <= fill_addr.tag;
        end
    end

endmodule

`default_nettype wire

/* hw/icache_data_store.sv */
/*
 * icache data store
 * one 64-bit line per way and set, both ways read in parallel
 * with one cycle latency, single fill write port
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module icache_data_store import icache_pkg::*; (
    input  wire logic                      clk,
    input  wire set_index_t                rd_index,
    input  wire logic                      wr_en,
    input  wire set_index_t                wr_index,
    input  wire logic                      wr_way,
    input  wire logic [`ICACHE_LINE_W-1:0] wr_line,
    output logic [`ICACHE_LINE_W-1:0]      rd_line0,
    output logic [`ICACHE_LINE_W-1:0]      rd_line1
);

    localparam int NUM_SETS = 1 << `ICACHE_SET_BITS;

    logic [`ICACHE_LINE_W-1:0] mem [2][NUM_SETS];

    // fill from the refill path
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_way][wr_index] <= wr_line;
        end
    end

    // registered read of both ways, tag compare picks one later
    always_ff @(posedge clk) begin
        rd_line0 <= mem[0][rd_index];
        rd_line1 <= mem[1][rd_index];
    end

endmodule

`default_nettype wire

/* hw/icache_refill_ctrl.sv */
/*
 * icache refill controller
 * fetch FSM, AXI4-Lite read master for line refills,
 * response register and flush handling
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module icache_refill_ctrl import icache_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      flush,
    input  wire fetch_req_t                req,
    input  wire logic                      resp_ready,
    input  wire logic                      hit,
    input  wire logic                      hit_way,
    input  wire logic [`ICACHE_LINE_W-1:0] rd_line0,
    input  wire logic [`ICACHE_LINE_W-1:0] rd_line1,
    input  wire logic                      arready,
    input  wire axi_r_t                    r,
    output logic                           req_ready,
    output fetch_resp_t                    resp,
    output fetch_addr_t                    lookup_addr,
    output logic                           fill,
    output fetch_addr_t                    fill_addr,
    output logic [`ICACHE_LINE_W-1:0]      fill_line,
    output axi_ar_t                        ar,
    output logic                           rready
);

    refill_state_e             state_q;
    refill_state_e             state_d;
    fetch_addr_t               req_addr_q;
    logic                      discard_q;
    logic [`ICACHE_INST_W-1:0] inst_q;
    logic                      err_q;
    logic                      r_done;
    logic                      r_ok;

    function automatic logic [`ICACHE_INST_W-1:0] pick_word(
        input logic [`ICACHE_LINE_W-1:0] line,
        input logic                      hi
    );
        return hi ? line[`ICACHE_LINE_W-1:`ICACHE_INST_W] : line[`ICACHE_INST_W-1:0];
    endfunction

    // rready is only high in DATA
    assign r_done = (state_q == DATA) && r.rvalid;
    assign r_ok   = (r.rresp == OKAY);

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req.valid) state_d = LOOKUP;
            LOOKUP:  state_d = flush ? IDLE : (hit ? RESP : ADDR);
            ADDR:    if (arready) state_d = DATA;
            DATA:    if (r.rvalid) state_d = (discard_q || flush) ? IDLE : RESP;
            RESP:    if (flush || resp_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // bus transfer in flight, flush only drops the response
    always_ff @(posedge clk) begin
        if (rst || state_q == IDLE) begin
            discard_q <= 1'b0;
        end else if (flush && (state_q == ADDR || state_q == DATA)) begin
            discard_q <= 1'b1;
        end
    end

    // ==============================
    // request and response data
    // ==============================
    always_ff @(posedge clk) begin
        if (req.valid && req_ready) begin
            req_addr_q <= fetch_addr_t'(req.pc);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && hit) begin
            inst_q <= pick_word(hit_way ? rd_line1 : rd_line0, req_addr_q.word_sel);
            err_q  <= 1'b0;
        end else if (r_done) begin
            inst_q <= pick_word(r.rdata, req_addr_q.word_sel);
            err_q  <= !r_ok;
        end
    end

    assign req_ready  = (state_q == IDLE);
    assign resp.valid = (state_q == RESP);
    assign resp.inst  = inst_q;
    assign resp.error = err_q;

    // follows the PC while idle so the data read starts at acceptance
    assign lookup_addr = (state_q == IDLE) ? fetch_addr_t'(req.pc) : req_addr_q;

    // no fill on an error response
    assign fill      = r_done && r_ok;
    assign fill_addr = req_addr_q;
    assign fill_line = r.rdata;

    // ==============================
    // AXI read master
    // ==============================
    assign ar.arvalid = (state_q == ADDR);
    assign ar.araddr  = {req_addr_q.tag, req_addr_q.index, {`ICACHE_OFFSET_BITS{1'b0}}};
    assign ar.arprot  = 3'b000;
    assign rready     = (state_q == DATA);

endmodule

`default_nettype wire

/* hw/ifu_icache.sv */
/*
 * fetch-side instruction cache, two-way set associative
 * fetch request/response ports and an AXI4-Lite read master
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module ifu_icache import icache_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       flush,
    input  wire fetch_req_t req,
    output logic            req_ready,
    output fetch_resp_t     resp,
    input  wire logic       resp_ready,
    output axi_ar_t         ar,
    input  wire logic       arready,
    input  wire axi_r_t     r,
    output logic            rready
);

    fetch_addr_t               lookup_addr;
    fetch_addr_t               fill_addr;
    logic                      fill;
    logic [`ICACHE_LINE_W-1:0] fill_line;
    logic                      hit;
    logic                      hit_way;
    logic                      fill_way;
    logic [`ICACHE_LINE_W-1:0] rd_line0;
    logic [`ICACHE_LINE_W-1:0] rd_line1;

    icache_tag_store u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .fill_way    (fill_way)
    );

    // fill way chosen by the tag store
    icache_data_store u_data_store (
        .clk      (clk),
        .rd_index (lookup_addr.index),
        .wr_en    (fill),
        .wr_index (fill_addr.index),
        .wr_way   (fill_way),
        .wr_line  (fill_line),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .req         (req),
        .resp_ready  (resp_ready),
        .hit         (hit),
        .hit_way     (hit_way),
        .rd_line0    (rd_line0),
        .rd_line1    (rd_line1),
        .arready     (arready),
        .r           (r),
        .req_ready   (req_ready),
        .resp        (resp),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .ar          (ar),
        .rready      (rready)
    );

endmodule

`default_nettype wire

/* verif/axi_lite_mem_model.sv */
/*
 * AXI4-Lite read slave for the icache testbench
 * random AR and R delays, line data from the word address,
 * SLVERR for the top address region
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module axi_lite_mem_model import icache_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire axi_ar_t                   ar,
    output logic                           arready,
    output axi_r_t                         r,
    input  wire logic                      rready,
    output int                             ar_count,
    output logic [`ICACHE_ADDR_W-1:0]      last_araddr
);

    logic                      ar_phase = 1'b1;
    logic                      ready_q  = 1'b0;
    axi_r_t                    r_q      = '0;
    logic [1:0]                wait_cnt = '0;
    logic                      ar_hs    = 1'b0;
    logic                      r_hs     = 1'b0;
    int                        count_q  = 0;
    logic [`ICACHE_ADDR_W-1:0] addr_q   = '0;

    function automatic logic [31:0] word_data(input logic [31:0] addr);
        logic [29:0] wa;
        wa = addr[31:2];
        return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    assign arready     = ready_q;
    assign r           = r_q;
    assign ar_count    = count_q;
    assign last_araddr = addr_q;

    // handshakes as the DUT sees them
    always @(posedge clk) begin
        ar_hs <= ar.arvalid && arready;
        r_hs  <= r.rvalid && rready;
        if (rst) begin
            count_q <= 0;
        end else if (ar.arvalid && arready) begin
            count_q <= count_q + 1;
            addr_q  <= ar.araddr;
        end
    end

    // ==============================
    // outputs change on the falling edge
    // ==============================
    always @(negedge clk) begin
        if (rst) begin
            ar_phase <= 1'b1;
            ready_q  <= 1'b0;
            r_q      <= '0;
            wait_cnt <= 2'($urandom_range(0, 3));
        end else if (ar_phase) begin
            if (ar_hs) begin
                ready_q  <= 1'b0;
                ar_phase <= 1'b0;
                wait_cnt <= 2'($urandom_range(0, 3));
            end else if (ar.arvalid && !ready_q) begin
                if (wait_cnt == 0) begin
                    ready_q <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end else if (r_hs) begin
            r_q.rvalid <= 1'b0;
            ar_phase   <= 1'b1;
            wait_cnt   <= 2'($urandom_range(0, 3));
        end else if (!r_q.rvalid) begin
            if (wait_cnt == 0) begin
                r_q.rvalid <= 1'b1;
                r_q.rdata  <= {word_data(addr_q + 32'd4), word_data(addr_q)};
                // reserved region at the top of the map
                r_q.rresp  <= (addr_q[31:28] == 4'hf) ? SLVERR : OKAY;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/ifu_icache_tb.sv */
/*
 * testbench for the fetch instruction cache
 * reference tags and victim bits predict hit or miss per fetch,
 * AXI4-Lite memory model with random delays on the bus side
 */
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module ifu_icache_tb import icache_pkg::*; ();

    localparam int NUM_RANDOM = 200;
    localparam int NUM_REQS   = NUM_RANDOM + 20;
    localparam int SETS       = 1 << `ICACHE_SET_BITS;

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    fetch_req_t  req;
    logic        req_ready;
    fetch_resp_t resp;
    logic        resp_ready;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    int          ar_count;
    logic [31:0] last_araddr;
    int          cycle        = 0;
    logic        random_ready = 1'b0;

    // reference copy of the cache directory
    logic [`ICACHE_TAG_W-1:0] ref_tag [2][SETS];
    logic                     ref_valid [2][SETS];
    logic                     ref_victim [SETS];

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ifu_icache UUT (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req        (req),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_ready (resp_ready),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready)
    );

    axi_lite_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .ar_count    (ar_count),
        .last_araddr (last_araddr)
    );

    // ==============================
    // bus and response rules
    // ==============================
    assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else stop_run("AR request dropped or changed before it was accepted");

    assert property (@(posedge clk) disable iff (rst)
        ar.arvalid |-> (ar.araddr[2:0] == 3'b000) && (ar.arprot == 3'b000))
        else stop_run("AR address not line aligned or arprot not zero");

    assert property (@(posedge clk) disable iff (rst)
        resp.valid && !resp_ready && !flush |=> resp.valid && $stable(resp))
        else stop_run("response changed or dropped before it was taken");

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", test, exp, act));
    endtask

    function automatic logic [31:0] word_value(input logic [31:0] pc);
        logic [29:0] wa;
        wa = pc[31:2];
        return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    function automatic logic ref_hit(input logic [31:0] pc);
        logic [`ICACHE_SET_BITS-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]    tag;
        idx = pc[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
        tag = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        return (ref_valid[0][idx] && ref_tag[0][idx] == tag) ||
               (ref_valid[1][idx] && ref_tag[1][idx] == tag);
    endfunction

    // invalid way first, otherwise the victim way
    task automatic ref_fill(input logic [31:0] pc);
        logic [`ICACHE_SET_BITS-1:0] idx;
        logic                        way;
        idx = pc[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
        if (!ref_valid[0][idx]) begin
            way = 1'b0;
        end else if (!ref_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = ref_victim[idx];
        end
        ref_valid[way][idx] = 1'b1;
        ref_tag[way][idx]   = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        ref_victim[idx]     = ~way;
    endtask

    task automatic wait_idle();
        while (!req_ready) begin
            @(negedge clk);
        end
    endtask

    // one fetch checked against the reference model
    task automatic fetch(input string name, input logic [31:0] pc);
        logic        exp_hit;
        logic        exp_err;
        logic        seen;
        logic        taken;
        int          ar_before;
        int          acc_cycle;
        exp_hit = ref_hit(pc);
        exp_err = (pc[31:28] == 4'hf);
        seen    = 1'b0;
        taken   = 1'b0;
        wait_idle();
        ar_before = ar_count;
        req.valid = 1'b1;
        req.pc    = pc;
        acc_cycle = cycle;
        @(negedge clk);
        req.valid = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (resp.valid) begin
                if (!seen) begin
                    seen = 1'b1;
                    if (exp_hit) begin
                        assert (cycle - acc_cycle == 2)
                            else report_mismatch({name, " hit latency"}, 2, cycle - acc_cycle);
                    end
                    assert (resp.error === exp_err)
                        else report_mismatch({name, " error"}, exp_err, resp.error);
                    if (!exp_err) begin
                        assert (resp.inst === word_value(pc))
                            else report_mismatch({name, " inst"}, word_value(pc), resp.inst);
                    end
                end
                resp_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            end else if (seen) begin
                taken      = 1'b1;
                resp_ready = 1'b0;
            end
        end
        assert (ar_count - ar_before == (exp_hit ? 0 : 1))
            else report_mismatch({name, " AR count"}, exp_hit ? 0 : 1, ar_count - ar_before);
        if (!exp_hit) begin
            assert (last_araddr === {pc[31:3], 3'b000})
                else report_mismatch({name, " araddr"}, {pc[31:3], 3'b000}, last_araddr);
        end
        if (!exp_hit && !exp_err) begin
            ref_fill(pc);
        end
    endtask

    // the fill still lands when a flush hits during the line read
    task automatic flush_during_miss(input logic [31:0] pc);
        int ar_before;
        wait_idle();
        ar_before = ar_count;
        req.valid = 1'b1;
        req.pc    = pc;
        @(negedge clk);
        req.valid = 1'b0;
        while (!ar.arvalid) begin
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        while (!req_ready) begin
            assert (!resp.valid) else stop_run("response returned after a flush during a miss");
            @(negedge clk);
        end
        assert (!resp.valid) else stop_run("response returned after a flush during a miss");
        assert (ar_count - ar_before == 1)
            else report_mismatch("flush miss AR count", 1, ar_count - ar_before);
        ref_fill(pc);
    endtask

    task automatic flush_during_lookup(input logic [31:0] pc);
        wait_idle();
        req.valid = 1'b1;
        req.pc    = pc;
        @(negedge clk);
        req.valid = 1'b0;
        flush     = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (req_ready && !resp.valid)
            else stop_run("flush during lookup did not return the cache to idle");
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        logic [31:0]                 pc;
        logic [`ICACHE_TAG_W-1:0]    rnd_tag;
        logic [`ICACHE_SET_BITS-1:0] rnd_set;
        logic                        rnd_word;
        void'($urandom(39));
        rst        = 1'b1;
        flush      = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_victim[s]   = 1'b0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready && !resp.valid && !ar.arvalid && !rready)
            else stop_run("outputs not idle after reset");

        fetch("cold miss", 32'h0000_1004);
        fetch("hit same pc", 32'h0000_1004);
        fetch("hit other word", 32'h0000_1000);

        // A, B and C all map to set 0x40
        fetch("replace A", 32'h0000_0200);
        fetch("replace B", 32'h0000_0a04);
        fetch("replace C", 32'h0000_1200);
        fetch("replace B again", 32'h0000_0a04);
        fetch("replace A again", 32'h0000_0200);

        fetch("slverr", 32'hf000_0010);
        fetch("slverr repeat", 32'hf000_0010);

        flush_during_miss(32'h0000_2018);
        fetch("flush miss refetch", 32'h0000_2018);
        flush_during_lookup(32'h0000_3008);
        fetch("lookup flush refetch", 32'h0000_3008);

        // few tags over four sets, so hits and evictions both occur
        random_ready = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_tag  = `ICACHE_TAG_W'($urandom_range(0, 5));
            rnd_set  = `ICACHE_SET_BITS'(8'h20 + $urandom_range(0, 3));
            rnd_word = 1'($urandom_range(0, 1));
            pc       = {rnd_tag, rnd_set, rnd_word, 2'b00};
            fetch("random stream", pc);
        end

        $display("Simulation passed");
        $finish;
    end

    // budget of 20 cycles per request
    initial begin
        #(NUM_REQS * 20 * 20);
        stop_run("timeout, the DUT stopped making progress");
    end

endmodule

`default_nettype wire

/* ifu_icache.f */
+incdir+include
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_refill_ctrl.sv
hw/ifu_icache.sv
verif/axi_lite_mem_model.sv
verif/ifu_icache_tb.sv
